// ==== rtl/adc_capture_params.svh ====
`ifndef ADC_CAPTURE_PARAMS_SVH
`define ADC_CAPTURE_PARAMS_SVH

////////////////////
// adc data path
////////////////////

`define ADC_W_DATA 18                  // bits per serial word, two's complement
`define ADC_N_CHAN 8                   // mux channels, one-hot valid per channel

////////////////////
// timing and decimation
////////////////////

`define ADC_OSR 4                      // samples per output, power of two
`define ADC_FRAME_LEN 24               // adc bit clocks per conversion frame
`define ADC_VALID_HOLD 4               // adc cycles the valid level stays up

// sum grows by log2(osr) bits, no overflow possible
`define ADC_W_SUM (`ADC_W_DATA + $clog2(`ADC_OSR))

`endif

// ==== rtl/adc_capture_pkg.sv ====
`default_nettype none

`include "adc_capture_params.svh"

package adc_capture_pkg;

	////////////////////
	// adc domain payload
	////////////////////

	// word pair from one frame, held stable across the clock crossing
	typedef struct packed {
		logic [`ADC_N_CHAN-1:0]        valid;   // one-hot channel marker
		logic signed [`ADC_W_DATA-1:0] data_a;  // line a word
		logic signed [`ADC_W_DATA-1:0] data_b;  // line b word
	} adc_sample_t;

	////////////////////
	// system domain records
	////////////////////

	// decimated sum of one line
	typedef struct packed {
		logic                         valid;  // one cycle per completed sum
		logic [`ADC_N_CHAN-1:0]       chan;   // one-hot
		logic signed [`ADC_W_SUM-1:0] sum;
	} accum_result_t;

	// merged output record
	typedef struct packed {
		logic                               valid;
		logic [$clog2(`ADC_N_CHAN)-1:0]     chan_idx;  // binary channel number
		logic signed [`ADC_W_SUM-1:0]       sum_a;
		logic signed [`ADC_W_SUM-1:0]       sum_b;
		logic signed [`ADC_W_SUM:0]         diff;      // sum_a - sum_b, one bit wider
	} capture_out_t;

endpackage

`default_nettype wire

// ==== rtl/adc_serial_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "adc_capture_params.svh"

// runs on the adc bit clock
// one frame = mux select, 18 data bits per line, then the valid pulse
module adc_serial_rx (
	input  logic                                adc_clk,
	input  logic                                reset_in,
	input  logic                                sdo_a,       // serial line a, msb first
	input  logic                                sdo_b,       // serial line b, msb first
	output logic [$clog2(`ADC_N_CHAN)-1:0]      adc_mux_sel, // channel under conversion
	output logic                                adc_frame,   // high in frame cycle 0
	output adc_capture_pkg::adc_sample_t        sample
);

	localparam int W_FCNT = $clog2(`ADC_FRAME_LEN);
	localparam int W_CHAN = $clog2(`ADC_N_CHAN);
	localparam int LOAD_CYC = `ADC_W_DATA - 1;              // last data bit cycle
	localparam int DROP_CYC = LOAD_CYC + `ADC_VALID_HOLD;   // valid falls after this

	logic                    run_q;       // low until the first frame starts
	logic [W_FCNT-1:0]       frame_cnt;
	logic                    frame_end;
	logic                    shift_en;
	logic                    load_word;
	logic                    drop_valid;
	logic [`ADC_W_DATA-1:0]  shift_a;
	logic [`ADC_W_DATA-1:0]  shift_b;
	logic [`ADC_W_DATA-1:0]  word_a;      // held payload
	logic [`ADC_W_DATA-1:0]  word_b;
	logic [`ADC_N_CHAN-1:0]  valid_q;
	logic [W_CHAN-1:0]       chan_ptr;

	////////////////////
	// frame decode
	////////////////////

	assign frame_end  = run_q && (frame_cnt == W_FCNT'(`ADC_FRAME_LEN - 1));
	assign shift_en   = run_q && (frame_cnt <= W_FCNT'(LOAD_CYC));  // cycles 0..17
	assign load_word  = run_q && (frame_cnt == W_FCNT'(LOAD_CYC));
	assign drop_valid = run_q && (frame_cnt == W_FCNT'(DROP_CYC));
	assign adc_frame  = run_q && (frame_cnt == '0);

	// frame counter, modulo frame length
	always_ff @(posedge adc_clk or posedge reset_in) begin
		if (reset_in) begin
			run_q     <= 1'b0;
			frame_cnt <= '0;
		end else begin
			run_q <= 1'b1;
			if (frame_end) begin
				frame_cnt <= '0;
			end else if (run_q) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	////////////////////
	// deserializer
	////////////////////

	// bits launched on the falling edge, taken here on the rising one
	always_ff @(posedge adc_clk) begin
		if (shift_en) begin
			shift_a <= {shift_a[`ADC_W_DATA-2:0], sdo_a};
			shift_b <= {shift_b[`ADC_W_DATA-2:0], sdo_b};
		end
	end

	// last bit goes straight into the held word
	always_ff @(posedge adc_clk) begin
		if (load_word) begin
			word_a <= {shift_a[`ADC_W_DATA-2:0], sdo_a};
			word_b <= {shift_b[`ADC_W_DATA-2:0], sdo_b};
		end
	end

	// valid up from cycle 18 for the hold time
	always_ff @(posedge adc_clk or posedge reset_in) begin
		if (reset_in) begin
			valid_q <= '0;
		end else if (load_word) begin
			valid_q <= `ADC_N_CHAN'(1) << chan_ptr;  // one-hot of current channel
		end else if (drop_valid) begin
			valid_q <= '0;
		end
	end

	////////////////////
	// channel mux
	////////////////////

	always_ff @(posedge adc_clk or posedge reset_in) begin
		if (reset_in) begin
			chan_ptr <= '0;
		end else if (frame_end) begin
			if (chan_ptr == W_CHAN'(`ADC_N_CHAN - 1)) begin
				chan_ptr <= '0;  // wrap
			end else begin
				chan_ptr <= chan_ptr + 1'b1;
			end
		end
	end

	assign adc_mux_sel   = chan_ptr;
	assign sample.valid  = valid_q;
	assign sample.data_a = word_a;
	assign sample.data_b = word_b;

endmodule

`default_nettype wire

// ==== rtl/adc_clk_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

// adc bit clock -> system clock
// only the reduced valid level is synchronized, payload is quasi-static
module adc_clk_sync (
	input  logic                          data_valid_rdc,  // 50 MHz system clock
	input  logic                          reset_in,
	input  adc_capture_pkg::adc_sample_t  sample_in,       // adc domain
	output logic                          sample_stb,      // one cycle per sample
	output adc_capture_pkg::adc_sample_t  sample_out
);

	import adc_capture_pkg::*;

	typedef enum logic [1:0] {
		ST_WAIT_PE,  // wait for level to rise
		ST_SEND,     // strobe out
		ST_WAIT_NE   // wait for level to fall
	} state_t;

	logic         valid_any;
	logic [1:0]   sync_q;      // two-flop synchronizer
	logic         valid_sync;
	logic         capture;
	state_t       state_q;
	state_t       state_d;
	adc_sample_t  sample_q;

	////////////////////
	// level sync
	////////////////////

	assign valid_any = |sample_in.valid;  // any channel
	assign valid_sync = sync_q[1];

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[0], valid_any};
		end
	end

	////////////////////
	// fsm
	////////////////////

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			state_q <= ST_WAIT_PE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;  // hold by default
		case (state_q)
			ST_WAIT_PE: if (valid_sync) state_d = ST_SEND;
			ST_SEND:    state_d = ST_WAIT_NE;
			ST_WAIT_NE: if (!valid_sync) state_d = ST_WAIT_PE;
			default:    state_d = ST_WAIT_PE;
		endcase
	end

	// payload sampled on the rise, adc side holds it for many cycles more
	assign capture = (state_q == ST_WAIT_PE) && valid_sync;

	always_ff @(posedge data_valid_rdc) begin
		if (capture) begin
			sample_q <= sample_in;
		end
	end

	assign sample_stb = (state_q == ST_SEND);  // lines up with sample_q
	assign sample_out = sample_q;

endmodule

`default_nettype wire

// ==== rtl/oversample_accum.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "adc_capture_params.svh"

// per-channel running sums, one output every osr samples of a channel
module oversample_accum (
	input  logic                             data_valid_rdc,
	input  logic                             reset_in,
	input  logic                             sample_stb,
	input  logic [`ADC_N_CHAN-1:0]           chan,    // one-hot
	input  logic signed [`ADC_W_DATA-1:0]    data,
	output adc_capture_pkg::accum_result_t   result
);

	localparam int W_CNT = $clog2(`ADC_OSR + 1);

	logic signed [`ADC_W_SUM-1:0]  data_ext;
	logic signed [`ADC_W_SUM-1:0]  sum_q [`ADC_N_CHAN];   // accumulator bank
	logic [W_CNT-1:0]              cnt_q [`ADC_N_CHAN];   // samples so far
	logic signed [`ADC_W_SUM-1:0]  sum_sel;               // sum incl. this sample
	logic                          last_sel;              // this sample completes it
	logic                          res_valid_q;
	logic [`ADC_N_CHAN-1:0]        res_chan_q;
	logic signed [`ADC_W_SUM-1:0]  res_sum_q;

	// sign extend to sum width
	assign data_ext = {{(`ADC_W_SUM - `ADC_W_DATA){data[`ADC_W_DATA-1]}}, data};

	////////////////////
	// channel select
	////////////////////

	always_comb begin
		sum_sel  = '0;
		last_sel = 1'b0;
		for (int ch = 0; ch < `ADC_N_CHAN; ch++) begin
			if (chan[ch]) begin  // at most one hit
				sum_sel  = sum_q[ch] + data_ext;
				last_sel = (cnt_q[ch] == W_CNT'(`ADC_OSR - 1));
			end
		end
	end

	////////////////////
	// bank update
	////////////////////

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			for (int ch = 0; ch < `ADC_N_CHAN; ch++) begin
				sum_q[ch] <= '0;
				cnt_q[ch] <= '0;
			end
		end else if (sample_stb) begin
			for (int ch = 0; ch < `ADC_N_CHAN; ch++) begin
				if (chan[ch]) begin
					if (last_sel) begin
						sum_q[ch] <= '0;  // restart, result goes out below
						cnt_q[ch] <= '0;
					end else begin
						sum_q[ch] <= sum_sel;
						cnt_q[ch] <= cnt_q[ch] + 1'b1;
					end
				end
			end
		end
	end

	////////////////////
	// decimated output
	////////////////////

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			res_valid_q <= 1'b0;
		end else begin
			res_valid_q <= sample_stb && last_sel;  // one cycle after strobe
		end
	end

	always_ff @(posedge data_valid_rdc) begin
		if (sample_stb) begin
			res_chan_q <= chan;
			res_sum_q  <= sum_sel;
		end
	end

	assign result.valid = res_valid_q;
	assign result.chan  = res_chan_q;
	assign result.sum   = res_sum_q;

endmodule

`default_nettype wire

// ==== rtl/sample_pair_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "adc_capture_params.svh"

// pairs the a and b sums into one output record
module sample_pair_merge (
	input  logic                             data_valid_rdc,
	input  logic                             reset_in,
	input  adc_capture_pkg::accum_result_t   result_a,
	input  adc_capture_pkg::accum_result_t   result_b,
	output adc_capture_pkg::capture_out_t    capture_out
);

	localparam int W_IDX = $clog2(`ADC_N_CHAN);

	logic                          valid_q;
	logic [W_IDX-1:0]              idx_d;      // encoded channel
	logic [W_IDX-1:0]              idx_q;
	logic signed [`ADC_W_SUM-1:0]  sum_a_q;
	logic signed [`ADC_W_SUM-1:0]  sum_b_q;
	logic signed [`ADC_W_SUM:0]    diff_q;

	// one-hot to binary, a and b run in lockstep so a alone is enough
	always_comb begin
		idx_d = '0;
		for (int ch = 0; ch < `ADC_N_CHAN; ch++) begin
			if (result_a.chan[ch]) begin
				idx_d = W_IDX'(ch);
			end
		end
	end

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= result_a.valid;
		end
	end

	always_ff @(posedge data_valid_rdc) begin
		if (result_a.valid) begin
			idx_q   <= idx_d;
			sum_a_q <= result_a.sum;
			sum_b_q <= result_b.sum;
			// extend both by one sign bit, difference can't overflow
			diff_q  <= {result_a.sum[`ADC_W_SUM-1], result_a.sum}
				- {result_b.sum[`ADC_W_SUM-1], result_b.sum};
		end
	end

	assign capture_out.valid    = valid_q;
	assign capture_out.chan_idx = idx_q;
	assign capture_out.sum_a    = sum_a_q;
	assign capture_out.sum_b    = sum_b_q;
	assign capture_out.diff     = diff_q;

endmodule

`default_nettype wire

// ==== rtl/adc_capture_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "adc_capture_params.svh"

// adc capture: deserializer -> cdc -> two accumulators -> merge
module adc_capture_top (
	input  logic                            data_valid_rdc,  // system clock
	input  logic                            adc_clk,         // adc bit clock
	input  logic                            reset_in,        // both domains
	input  logic                            sdo_a,
	input  logic                            sdo_b,
	output logic [$clog2(`ADC_N_CHAN)-1:0]  adc_mux_sel,
	output logic                            adc_frame,
	output adc_capture_pkg::capture_out_t   capture_out
);

	import adc_capture_pkg::*;

	adc_sample_t    adc_sample;   // adc clock domain
	adc_sample_t    sync_sample;  // system domain
	logic           sample_stb;
	accum_result_t  result_a;
	accum_result_t  result_b;

	////////////////////
	// adc domain
	////////////////////

	adc_serial_rx adc_serial_rx_i (
		.adc_clk     (adc_clk),
		.reset_in    (reset_in),
		.sdo_a       (sdo_a),
		.sdo_b       (sdo_b),
		.adc_mux_sel (adc_mux_sel),
		.adc_frame   (adc_frame),
		.sample      (adc_sample)
	);

	adc_clk_sync adc_clk_sync_i (
		.data_valid_rdc (data_valid_rdc),
		.reset_in       (reset_in),
		.sample_in      (adc_sample),
		.sample_stb     (sample_stb),
		.sample_out     (sync_sample)
	);

	////////////////////
	// system domain
	////////////////////

	oversample_accum accum_a (
		.data_valid_rdc (data_valid_rdc),
		.reset_in       (reset_in),
		.sample_stb     (sample_stb),
		.chan           (sync_sample.valid),
		.data           (sync_sample.data_a),
		.result         (result_a)
	);

	oversample_accum accum_b (
		.data_valid_rdc (data_valid_rdc),
		.reset_in       (reset_in),
		.sample_stb     (sample_stb),
		.chan           (sync_sample.valid),  // same channel as line a
		.data           (sync_sample.data_b),
		.result         (result_b)
	);

	sample_pair_merge sample_pair_merge_i (
		.data_valid_rdc (data_valid_rdc),
		.reset_in       (reset_in),
		.result_a       (result_a),
		.result_b       (result_b),
		.capture_out    (capture_out)
	);

endmodule

`default_nettype wire

// ==== verif/adc_capture_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "adc_capture_params.svh"

// protocol checks on the system side of the capture path
module adc_capture_properties (
	input  logic                            data_valid_rdc,
	input  logic                            reset_in,
	input  logic                            sample_stb,
	input  adc_capture_pkg::adc_sample_t    sync_sample,
	input  adc_capture_pkg::accum_result_t  result_a,
	input  adc_capture_pkg::accum_result_t  result_b,
	input  adc_capture_pkg::capture_out_t   capture_out
);

	import adc_capture_pkg::*;

	int unsigned fail_cnt = 0;  // read by the testbench at the end

	////////////////////
	// synchronizer
	////////////////////

	stb_one_cycle: assert property (@(posedge data_valid_rdc) disable iff (reset_in)
		sample_stb |=> !sample_stb)
		else begin
			fail_cnt++;
			$error("sample strobe held for more than one cycle");
		end

	// exactly one channel marked per strobe
	stb_onehot: assert property (@(posedge data_valid_rdc) disable iff (reset_in)
		sample_stb |-> $onehot(sync_sample.valid))
		else begin
			fail_cnt++;
			$error("synchronized valid vector is not one-hot");
		end

	////////////////////
	// accumulators and merge
	////////////////////

	ab_lockstep: assert property (@(posedge data_valid_rdc) disable iff (reset_in)
		result_a.valid == result_b.valid)
		else begin
			fail_cnt++;
			$error("accumulator a and b valid flags disagree");
		end

	out_latency: assert property (@(posedge data_valid_rdc) disable iff (reset_in)
		capture_out.valid |-> $past(sample_stb, 2))
		else begin
			fail_cnt++;
			$error("output record not two cycles after the strobe");
		end

endmodule

bind adc_capture_top adc_capture_properties adc_capture_properties_i (
	.data_valid_rdc (data_valid_rdc),
	.reset_in       (reset_in),
	.sample_stb     (sample_stb),
	.sync_sample    (sync_sample),
	.result_a       (result_a),
	.result_b       (result_b),
	.capture_out    (capture_out)
);

`default_nettype wire

// ==== verif/adc_capture_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "adc_capture_params.svh"

module adc_capture_tb;

	import adc_capture_pkg::*;

	localparam int FRAMES_ALL = 220;  // all tests together, with slack
	localparam real WATCHDOG_NS = FRAMES_ALL * `ADC_FRAME_LEN * 58.0 + 20000.0;

	logic data_valid_rdc = 1'b0;
	logic adc_clk = 1'b0;
	logic reset_in = 1'b1;
	logic sdo_a = 1'b0;
	logic sdo_b = 1'b0;
	logic [2:0] adc_mux_sel;
	logic adc_frame;
	capture_out_t capture_out;

	int seed = 18147;
	int mode = 0;            // 0 constant, 1 random, 2 b above a
	int err_cnt = 0;
	int rec_cnt = 0;         // records checked in this test
	int rec_all = 0;
	int frames_sent = 0;
	int ref_a [`ADC_N_CHAN]; // reference sums of the words sent
	int ref_b [`ADC_N_CHAN];
	int ref_n [`ADC_N_CHAN];
	int exp_chan = 0;        // channel the mux should be on
	int bit_k = 99;          // bit position within the frame, 99 idle
	int last_idx = -1;
	logic [17:0] word_a;
	logic [17:0] word_b;
	capture_out_t exp_q [$];
	capture_out_t exp_rec;

	adc_capture_top adc_capture_top_i (
		.data_valid_rdc (data_valid_rdc),
		.adc_clk        (adc_clk),
		.reset_in       (reset_in),
		.sdo_a          (sdo_a),
		.sdo_b          (sdo_b),
		.adc_mux_sel    (adc_mux_sel),
		.adc_frame      (adc_frame),
		.capture_out    (capture_out)
	);

	initial forever #10 data_valid_rdc = ~data_valid_rdc;  // 50 MHz

	// off-grid so adc edges never meet system edges
	initial begin
		#0.5;
		forever #29 adc_clk = ~adc_clk;
	end

	////////////////////
	// adc model
	////////////////////

	task automatic pick_words();
		int r;
		r = $random(seed);
		case (mode)
			0: begin
				word_a = 18'h0A5C3;
				word_b = 18'h0A5C3;
			end
			1: begin
				word_a = r[17:0];
				if (r[20:18] == 3'd0) word_a = 18'h20000;  // negative full scale
				r = $random(seed);
				word_b = r[17:0];
				if (r[20:18] == 3'd1) word_b = 18'h20000;
			end
			default: begin
				word_a = {2'b00, r[15:0]};
				word_b = word_a + 18'd1000 + {10'd0, r[27:20]};  // always above a
			end
		endcase
	endtask

	always @(negedge adc_clk) begin
		if (reset_in) begin
			bit_k = 99;
			exp_chan = 0;
			sdo_a <= 1'b0;
			sdo_b <= 1'b0;
			for (int ch = 0; ch < `ADC_N_CHAN; ch++) begin
				ref_a[ch] = 0;
				ref_b[ch] = 0;
				ref_n[ch] = 0;
			end
			exp_q.delete();
		end else if (adc_frame) begin
			assert (adc_mux_sel == exp_chan[2:0]) else begin
				$display("ERROR adc_mux_sel got %h expected %h", adc_mux_sel, exp_chan[2:0]);
				err_cnt++;
			end
			pick_words();
			ref_a[exp_chan] += $signed(word_a);
			ref_b[exp_chan] += $signed(word_b);
			ref_n[exp_chan]++;
			if (ref_n[exp_chan] == `ADC_OSR) begin  // channel completes a sum
				exp_rec.valid = 1'b1;
				exp_rec.chan_idx = exp_chan[2:0];
				exp_rec.sum_a = ref_a[exp_chan][19:0];
				exp_rec.sum_b = ref_b[exp_chan][19:0];
				exp_rec.diff = 21'(ref_a[exp_chan] - ref_b[exp_chan]);
				exp_q.push_back(exp_rec);
				ref_a[exp_chan] = 0;
				ref_b[exp_chan] = 0;
				ref_n[exp_chan] = 0;
			end
			exp_chan = (exp_chan + 1) % `ADC_N_CHAN;
			frames_sent++;
			sdo_a <= word_a[17];  // msb first
			sdo_b <= word_b[17];
			bit_k = 1;
		end else if (bit_k < `ADC_W_DATA) begin
			sdo_a <= word_a[17 - bit_k];
			sdo_b <= word_b[17 - bit_k];
			bit_k++;
		end
	end

	////////////////////
	// output checks
	////////////////////

	always @(negedge data_valid_rdc) begin
		if (!reset_in && capture_out.valid) begin
			if (exp_q.size() == 0) begin
				$display("output record arrived with no reference sum waiting");
				err_cnt++;
			end else begin
				exp_rec = exp_q.pop_front();
				assert (capture_out.chan_idx == exp_rec.chan_idx) else begin
					$display("ERROR capture_out.chan_idx got %h expected %h",
						capture_out.chan_idx, exp_rec.chan_idx);
					err_cnt++;
				end
				assert (capture_out.sum_a == exp_rec.sum_a) else begin
					$display("ERROR capture_out.sum_a got %h expected %h",
						capture_out.sum_a, exp_rec.sum_a);
					err_cnt++;
				end
				assert (capture_out.sum_b == exp_rec.sum_b) else begin
					$display("ERROR capture_out.sum_b got %h expected %h",
						capture_out.sum_b, exp_rec.sum_b);
					err_cnt++;
				end
				assert (capture_out.diff == exp_rec.diff) else begin
					$display("ERROR capture_out.diff got %h expected %h",
						capture_out.diff, exp_rec.diff);
					err_cnt++;
				end
				// round robin order
				assert (last_idx < 0 || capture_out.chan_idx == 3'(last_idx + 1)) else begin
					$display("ERROR capture_out.chan_idx got %h expected %h",
						capture_out.chan_idx, 3'(last_idx + 1));
					err_cnt++;
				end
				if (mode == 2) begin
					assert (capture_out.diff[`ADC_W_SUM]) else begin
						$display("difference is not negative although b was above a");
						err_cnt++;
					end
				end
				last_idx = capture_out.chan_idx;
				rec_cnt++;
				rec_all++;
			end
		end
	end

	////////////////////
	// test flow
	////////////////////

	task automatic apply_reset();
		@(negedge data_valid_rdc);
		reset_in <= 1'b1;
		repeat (16) @(negedge data_valid_rdc);
		assert (!capture_out.valid && !adc_frame && adc_mux_sel == 3'd0) else begin
			$display("outputs not idle during reset");
			err_cnt++;
		end
		rec_cnt = 0;
		frames_sent = 0;
		last_idx = -1;
		reset_in <= 1'b0;
	endtask

	task automatic run_test(input string name, input int test_mode, input int n_rec);
		int err_start;
		err_start = err_cnt;
		mode = test_mode;
		apply_reset();
		wait (rec_cnt >= n_rec);
		$display("test %s: %0d records, %0d errors", name, rec_cnt, err_cnt - err_start);
	endtask

	initial begin
		int total;
		int err_start;
		run_test("constant", 0, 8);
		run_test("random", 1, 16);
		run_test("b_above_a", 2, 8);
		// reset with partial sums in the bank
		err_start = err_cnt;
		mode = 1;
		apply_reset();
		wait (frames_sent >= 20);
		apply_reset();
		wait (rec_cnt >= 8);
		$display("test reset_mid_run: %0d records, %0d errors", rec_cnt, err_cnt - err_start);
		total = err_cnt + adc_capture_top_i.adc_capture_properties_i.fail_cnt;
		$display("tests 4, records %0d, errors %0d", rec_all, total);
		if (total == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all tests finished");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/adc_capture_pkg.sv
rtl/adc_serial_rx.sv
rtl/adc_clk_sync.sv
rtl/oversample_accum.sv
rtl/sample_pair_merge.sv
rtl/adc_capture_top.sv
verif/adc_capture_properties.sv
verif/adc_capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the adc capture testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module adc_capture_tb -o sim_adc
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_adc +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1
